/* common/i4_pix_pkg.sv */
// Pixel, block and macroblock types for the intra 4x4 mode decision
// Edge neighbour struct and sub-block geometry constants

package i4_pix_pkg;

    localparam int BLK_DIM  = 4;
    localparam int MB_DIM   = 16;
    localparam int NUM_BLKS = 16;

    typedef logic [7:0] pix_t;

    // Row major, pixel 0 in the low byte
    typedef pix_t [BLK_DIM*BLK_DIM-1:0] blk4_t;
    typedef pix_t [MB_DIM*MB_DIM-1:0]   mb_t;

    // 16 pixels above the macroblock plus the top-right pixel
    typedef pix_t [MB_DIM:0]   top_line_t;
    typedef pix_t [MB_DIM-1:0] left_col_t;

    typedef logic [3:0] blk_idx_t;

    typedef struct packed {
        pix_t               top_left;
        pix_t [BLK_DIM-1:0] top;
        pix_t               top_right;
        pix_t [BLK_DIM-1:0] left;
    } edge_t;

endpackage

/* common/i4_mode_pkg.sv */
// Intra 4x4 mode enum, per-mode fixed costs and score types
// Per-block decision result and the macroblock mode map

package i4_mode_pkg;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    localparam int NUM_MODES = 4;

    // Header bit cost of each mode, index is the mode
    localparam logic [NUM_MODES-1:0][15:0] FIXED_COST =
        {16'd1874, 16'd1723, 16'd1151, 16'd40};

    localparam int SSE_SHIFT = 8;

    typedef logic [15:0] lambda_t;
    typedef logic [31:0] sse_t;
    typedef logic [63:0] score_t;

    typedef i4_pix_pkg::blk4_t [NUM_MODES-1:0] pred_set_t;

    typedef struct packed {
        mode_t             mode;
        score_t            score;
        i4_pix_pkg::blk4_t pred;
    } mode_result_t;

    // Block k sits in bits 2k+1:2k
    typedef mode_t [i4_pix_pkg::NUM_BLKS-1:0] mode_map_t;

endpackage

/* predict/i4_predictor.sv */
// DC, TM, VE and HE predictions of one 4x4 sub-block
// Purely combinational, driven from the current edge pixels

`timescale 1ns/1ps

module i4_predictor (
    input  i4_pix_pkg::edge_t      edge_i,
    output i4_mode_pkg::pred_set_t preds_o
);

    import i4_pix_pkg::*;
    import i4_mode_pkg::*;

    // (a + 2b + c + 2) >> 2
    function automatic pix_t avg3(input pix_t a, input pix_t b, input pix_t c);
        logic [9:0] sum;
        sum = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return sum[9:2];
    endfunction

    function automatic pix_t tm_clip(input pix_t top, input pix_t left, input pix_t corner);
        logic signed [10:0] val;
        val = $signed({3'b000, top}) + $signed({3'b000, left}) - $signed({3'b000, corner});
        if (val < 0) begin
            return 8'd0;
        end
        if (val > 255) begin
            return 8'd255;
        end
        return val[7:0];
    endfunction

    // Extended edges, index 0 is the corner pixel
    pix_t [BLK_DIM+1:0] top_ext;
    pix_t [BLK_DIM+1:0] left_ext;
    logic [10:0]        dc_sum;
    pix_t               dc_val;

    assign top_ext  = {edge_i.top_right, edge_i.top, edge_i.top_left};
    // Bottom row of HE repeats the last left pixel
    assign left_ext = {edge_i.left[BLK_DIM-1], edge_i.left, edge_i.top_left};

    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < BLK_DIM; i++) begin
            dc_sum = dc_sum + {3'b000, edge_i.top[i]} + {3'b000, edge_i.left[i]};
        end
    end

    assign dc_val = dc_sum[10:3];

    //----------------------------------------------------------------------
    // Per-pixel predictions
    //----------------------------------------------------------------------
    always_comb begin
        for (int y = 0; y < BLK_DIM; y++) begin
            for (int x = 0; x < BLK_DIM; x++) begin
                preds_o[MODE_DC][y*BLK_DIM+x] = dc_val;
                preds_o[MODE_TM][y*BLK_DIM+x] =
                    tm_clip(edge_i.top[x], edge_i.left[y], edge_i.top_left);
                preds_o[MODE_VE][y*BLK_DIM+x] =
                    avg3(top_ext[x], top_ext[x+1], top_ext[x+2]);
                preds_o[MODE_HE][y*BLK_DIM+x] =
                    avg3(left_ext[y], left_ext[y+1], left_ext[y+2]);
            end
        end
    end

endmodule

/* predict/i4_edge_ctx.sv */
// Neighbour context for the sub-block being decided
// Line, left and corner registers rotated after each chosen block

`timescale 1ns/1ps

module i4_edge_ctx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mb_begin_i,
    input  logic                  update_i,
    input  i4_pix_pkg::blk_idx_t  blk_idx_i,
    input  i4_pix_pkg::top_line_t top_i,
    input  i4_pix_pkg::left_col_t left_i,
    input  i4_pix_pkg::pix_t      top_left_i,
    input  i4_pix_pkg::blk4_t     chosen_i,
    output i4_pix_pkg::edge_t     edge_o
);

    import i4_pix_pkg::*;

    // Bottom line of the last reconstructed row of blocks
    pix_t [MB_DIM-1:0]  line_q;
    pix_t [BLK_DIM-1:0] left_q;
    pix_t               corner_q;
    logic [1:0]         blk_row;
    logic [1:0]         blk_col;

    assign blk_row = blk_idx_i[3:2];
    assign blk_col = blk_idx_i[1:0];

    //----------------------------------------------------------------------
    // Rotation after each stored block
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mb_begin_i) begin
            line_q <= top_i[MB_DIM-1:0];
        end else if (update_i) begin
            for (int x = 0; x < BLK_DIM; x++) begin
                line_q[blk_col*BLK_DIM+x] <= chosen_i[(BLK_DIM-1)*BLK_DIM+x];
                left_q[x] <= chosen_i[x*BLK_DIM+BLK_DIM-1];
            end
            // Old top pixel above the right column
            corner_q <= line_q[blk_col*BLK_DIM+BLK_DIM-1];
        end
    end

    //----------------------------------------------------------------------
    // Edge selection for the current block
    //----------------------------------------------------------------------
    always_comb begin
        for (int x = 0; x < BLK_DIM; x++) begin
            edge_o.top[x] = line_q[blk_col*BLK_DIM+x];
            if (blk_col == 2'd0) begin
                edge_o.left[x] = left_i[blk_row*BLK_DIM+x];
            end else begin
                edge_o.left[x] = left_q[x];
            end
        end

        // Right column of blocks reuses the macroblock top-right
        if (blk_col == 2'd3) begin
            edge_o.top_right = top_i[MB_DIM];
        end else begin
            edge_o.top_right = line_q[blk_col*BLK_DIM+BLK_DIM];
        end

        if (blk_col != 2'd0) begin
            edge_o.top_left = corner_q;
        end else if (blk_row == 2'd0) begin
            edge_o.top_left = top_left_i;
        end else begin
            edge_o.top_left = left_i[blk_row*BLK_DIM-1];
        end
    end

    // Controller never loads and rotates in one cycle
    a_no_load_and_rotate: assert property (
        @(posedge clk) disable iff (!rst_n) !(mb_begin_i && update_i)
    );

endmodule

/* score/i4_mode_scorer.sv */
// Row-serial SSE of all four modes against the source block
// Score forming and lowest-score mode selection

`timescale 1ns/1ps

module i4_mode_scorer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  i4_pix_pkg::blk_idx_t      blk_idx_i,
    input  i4_pix_pkg::mb_t           mb_src_i,
    input  i4_mode_pkg::lambda_t      lambda_i,
    input  i4_mode_pkg::pred_set_t    preds_i,
    output i4_mode_pkg::mode_result_t result_o,
    output logic                      done_o
);

    import i4_pix_pkg::*;
    import i4_mode_pkg::*;

    function automatic sse_t sq_diff(input pix_t a, input pix_t b);
        pix_t ad;
        ad = (a > b) ? a - b : b - a;
        return sse_t'(ad) * sse_t'(ad);
    endfunction

    logic                         busy_q;
    logic                         done_q;
    logic [1:0]                   row_q;
    pix_t [BLK_DIM-1:0]           src_row;
    sse_t [NUM_MODES-1:0]         row_sse;
    sse_t [NUM_MODES-1:0]         acc_q;
    score_t [NUM_MODES-1:0]       score_c;
    mode_t                        best_mode;
    score_t                       best_score;
    mode_result_t                 result_q;

    always_comb begin
        for (int x = 0; x < BLK_DIM; x++) begin
            src_row[x] = mb_src_i[(blk_idx_i[3:2]*BLK_DIM+row_q)*MB_DIM
                                  + blk_idx_i[1:0]*BLK_DIM + x];
        end
        for (int m = 0; m < NUM_MODES; m++) begin
            row_sse[m] = '0;
            for (int x = 0; x < BLK_DIM; x++) begin
                row_sse[m] = row_sse[m] + sq_diff(src_row[x], preds_i[m][row_q*BLK_DIM+x]);
            end
        end
    end

    //----------------------------------------------------------------------
    // Four row cycles, then one scoring cycle
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            row_q  <= '0;
        end else begin
            done_q <= busy_q && (row_q == 2'(BLK_DIM-1));
            if (start_i) begin
                busy_q <= 1'b1;
                row_q  <= '0;
            end else if (busy_q) begin
                row_q <= row_q + 2'd1;
                if (row_q == 2'(BLK_DIM-1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (busy_q) begin
            for (int m = 0; m < NUM_MODES; m++) begin
                acc_q[m] <= acc_q[m] + row_sse[m];
            end
        end
    end

    // Strict compare keeps the lower mode on a tie
    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            score_c[m] = (score_t'(acc_q[m]) << SSE_SHIFT)
                       + score_t'(32'(lambda_i) * 32'(FIXED_COST[m]));
        end
        best_mode  = MODE_DC;
        best_score = score_c[0];
        for (int m = 1; m < NUM_MODES; m++) begin
            if (score_c[m] < best_score) begin
                best_mode  = mode_t'(m);
                best_score = score_c[m];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done_q) begin
            result_q.mode  <= best_mode;
            result_q.score <= best_score;
            result_q.pred  <= preds_i[best_mode];
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;

    // Controller waits for done before issuing the next block
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start_i |-> !busy_q && !done_q
    );

endmodule

/* source/i4_mode_ctrl.sv */
// Macroblock sequencing FSM for the intra 4x4 decision
// Sub-block counter and per-block issue and store strobes

`timescale 1ns/1ps

module i4_mode_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 score_done_i,
    output logic                 mb_begin_o,
    output logic                 score_start_o,
    output logic                 store_o,
    output i4_pix_pkg::blk_idx_t blk_idx_o,
    output logic                 done_o
);

    import i4_pix_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        ISSUE,
        WAIT,
        STORE,
        DONE
    } state_t;

    state_t   state_q;
    state_t   state_d;
    blk_idx_t blk_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            blk_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == INIT) begin
                blk_q <= '0;
            end else if (state_q == STORE) begin
                blk_q <= blk_q + 4'd1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = INIT;
            INIT:    state_d = ISSUE;
            ISSUE:   state_d = WAIT;
            WAIT:    if (score_done_i) state_d = STORE;
            STORE:   state_d = (blk_q == blk_idx_t'(NUM_BLKS-1)) ? DONE : ISSUE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign mb_begin_o    = (state_q == INIT);
    assign score_start_o = (state_q == ISSUE);
    assign store_o       = (state_q == STORE);
    assign done_o        = (state_q == DONE);
    assign blk_idx_o     = blk_q;

    // Scorer only reports while a block is outstanding
    a_score_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) score_done_i |-> state_q == WAIT
    );

endmodule

/* source/i4_mb_writeback.sv */
// Reconstructed macroblock, mode map and running total score
// Written one sub-block per store strobe

`timescale 1ns/1ps

module i4_mb_writeback (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear_i,
    input  logic                      store_i,
    input  i4_pix_pkg::blk_idx_t      blk_idx_i,
    input  i4_mode_pkg::mode_result_t result_i,
    output i4_pix_pkg::mb_t           y_rec_o,
    output i4_mode_pkg::mode_map_t    modes_o,
    output i4_mode_pkg::score_t       total_score_o
);

    import i4_pix_pkg::*;
    import i4_mode_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_rec_o       <= '0;
            modes_o       <= {NUM_BLKS{MODE_DC}};
            total_score_o <= '0;
        end else if (clear_i) begin
            y_rec_o       <= '0;
            modes_o       <= {NUM_BLKS{MODE_DC}};
            total_score_o <= '0;
        end else if (store_i) begin
            // Chosen prediction is the reconstruction
            for (int y = 0; y < BLK_DIM; y++) begin
                for (int x = 0; x < BLK_DIM; x++) begin
                    y_rec_o[(blk_idx_i[3:2]*BLK_DIM+y)*MB_DIM + blk_idx_i[1:0]*BLK_DIM + x]
                        <= result_i.pred[y*BLK_DIM+x];
                end
            end
            modes_o[blk_idx_i] <= result_i.mode;
            total_score_o      <= total_score_o + result_i.score;
        end
    end

endmodule

/* source/i4_pick_best.sv */
// Top level of the intra 4x4 best-mode picker
// Controller, edge context, predictor, scorer and writeback

`timescale 1ns/1ps

module i4_pick_best (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  i4_mode_pkg::lambda_t   lambda_i,
    input  i4_pix_pkg::mb_t        mb_src_i,
    input  i4_pix_pkg::top_line_t  top_i,
    input  i4_pix_pkg::left_col_t  left_i,
    input  i4_pix_pkg::pix_t       top_left_i,
    output i4_pix_pkg::mb_t        y_rec_o,
    output i4_mode_pkg::mode_map_t modes_o,
    output i4_mode_pkg::score_t    total_score_o,
    output logic                   done_o
);

    import i4_pix_pkg::*;
    import i4_mode_pkg::*;

    logic         mb_begin;
    logic         score_start;
    logic         score_done;
    logic         store;
    blk_idx_t     blk_idx;
    edge_t        edge_pix;
    pred_set_t    preds;
    mode_result_t result;

    i4_mode_ctrl u_i4_mode_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .score_done_i  (score_done),
        .mb_begin_o    (mb_begin),
        .score_start_o (score_start),
        .store_o       (store),
        .blk_idx_o     (blk_idx),
        .done_o        (done_o)
    );

    i4_edge_ctx u_i4_edge_ctx (
        .clk        (clk),
        .rst_n      (rst_n),
        .mb_begin_i (mb_begin),
        .update_i   (store),
        .blk_idx_i  (blk_idx),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .chosen_i   (result.pred),
        .edge_o     (edge_pix)
    );

    i4_predictor u_i4_predictor (
        .edge_i  (edge_pix),
        .preds_o (preds)
    );

    i4_mode_scorer u_i4_mode_scorer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (score_start),
        .blk_idx_i (blk_idx),
        .mb_src_i  (mb_src_i),
        .lambda_i  (lambda_i),
        .preds_i   (preds),
        .result_o  (result),
        .done_o    (score_done)
    );

    i4_mb_writeback u_i4_mb_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear_i       (mb_begin),
        .store_i       (store),
        .blk_idx_i     (blk_idx),
        .result_i      (result),
        .y_rec_o       (y_rec_o),
        .modes_o       (modes_o),
        .total_score_o (total_score_o)
    );

endmodule

/* tb/tb_i4_pick_best.sv */
// Testbench for the intra 4x4 best-mode picker
// Records from the stimulus file, compare task and final report

`timescale 1ns/1ps

module tb_i4_pick_best;

    import i4_pix_pkg::*;
    import i4_mode_pkg::*;

    localparam int DONE_TIMEOUT    = 200;
    localparam int SECOND_START_AT = 10;
    localparam int QUIET_CYCLES    = 20;
    localparam int BLK_CYCLES      = 7;
    // One INIT cycle, seven cycles per block and the DONE cycle
    localparam int DONE_LATENCY    = 1 + NUM_BLKS * BLK_CYCLES + 1;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    lambda_t   lambda_i;
    mb_t       mb_src_i;
    top_line_t top_i;
    left_col_t left_i;
    pix_t      top_left_i;
    mb_t       y_rec_o;
    mode_map_t modes_o;
    score_t    total_score_o;
    logic      done_o;

    int                 err_count;
    int                 test_count;
    int                 failed_tests;
    int                 fd;
    logic [8*32-1:0]    tok;
    logic [8*32-1:0]    test_name;
    logic [8*400-1:0]   skip_line;

    i4_pick_best u_i4_pick_best (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .lambda_i      (lambda_i),
        .mb_src_i      (mb_src_i),
        .top_i         (top_i),
        .left_i        (left_i),
        .top_left_i    (top_left_i),
        .y_rec_o       (y_rec_o),
        .modes_o       (modes_o),
        .total_score_o (total_score_o),
        .done_o        (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [255:0] label, input logic [255:0] field,
                               input logic [2047:0] expected, input logic [2047:0] actual);
        if (expected !== actual) begin
            $display("FAIL %0s %0s expected %0h actual %0h", label, field, expected, actual);
            err_count++;
        end
    endtask

    // 16 row words, row 0 first, pixel 0 in the low byte
    task automatic read_mb(output logic [2047:0] mb);
        int           code;
        logic [127:0] row_val;
        for (int r = 0; r < MB_DIM; r++) begin
            code = $fscanf(fd, "%h", row_val);
            if (code != 1) begin
                $display("ERROR: test %0s, a macroblock row is missing from the stimulus file",
                         test_name);
                err_count++;
            end
            mb[r*128 +: 128] = row_val;
        end
    endtask

    //----------------------------------------------------------------------
    // Wait for done, with a second start pulse that must be ignored
    //----------------------------------------------------------------------
    task automatic wait_for_done(output int dones, output int latency);
        int cycles;
        dones   = 0;
        latency = 0;
        cycles  = 0;
        while (dones == 0 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            start_i = (cycles == SECOND_START_AT);
            if (done_o) begin
                dones++;
                latency = cycles;
            end
        end
        start_i = 1'b0;
        if (dones == 0) begin
            $display("ERROR: test %0s, done never arrived within %0d cycles",
                     test_name, DONE_TIMEOUT);
            err_count++;
        end else begin
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                if (done_o) begin
                    dones++;
                end
            end
        end
    endtask

    task automatic run_record();
        int            code;
        int            dones;
        int            latency;
        int            errs_before;
        logic [15:0]   lam_val;
        logic [7:0]    tl_val;
        logic [135:0]  top_val;
        logic [127:0]  left_val;
        logic [2047:0] src_flat;
        logic [2047:0] rec_flat;
        logic [31:0]   exp_modes;
        logic [63:0]   exp_total;
        errs_before = err_count;
        code = $fscanf(fd, "%h %h %h %h", lam_val, tl_val, top_val, left_val);
        if (code != 4) begin
            $display("ERROR: test %0s, edge fields are missing from the stimulus file",
                     test_name);
            err_count++;
        end
        read_mb(src_flat);
        code = $fscanf(fd, "%h %h", exp_modes, exp_total);
        if (code != 2) begin
            $display("ERROR: test %0s, expected modes or total missing from the stimulus file",
                     test_name);
            err_count++;
        end
        read_mb(rec_flat);

        @(negedge clk);
        lambda_i   = lam_val;
        top_left_i = tl_val;
        top_i      = top_val;
        left_i     = left_val;
        mb_src_i   = src_flat;
        start_i    = 1'b1;
        wait_for_done(dones, latency);

        if (dones > 0) begin
            check_value(test_name, "done_pulses", 1, dones);
            check_value(test_name, "done_latency", DONE_LATENCY, latency);
            check_value(test_name, "modes", exp_modes, modes_o);
            check_value(test_name, "total_score", exp_total, total_score_o);
            check_value(test_name, "y_rec", rec_flat, y_rec_o);
        end
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0s: ok", test_name);
        end else begin
            $display("test %0s: failed", test_name);
            failed_tests++;
        end
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        int code;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        lambda_i     = '0;
        mb_src_i     = '0;
        top_i        = '0;
        left_i       = '0;
        top_left_i   = '0;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle outputs before any start
        test_name = "reset";
        check_value(test_name, "done", 0, done_o);
        check_value(test_name, "modes", 0, modes_o);
        check_value(test_name, "total_score", 0, total_score_o);
        check_value(test_name, "y_rec", 0, y_rec_o);
        test_count++;
        if (err_count == 0) begin
            $display("test reset: ok");
        end else begin
            $display("test reset: failed");
            failed_tests++;
        end

        fd = $fopen("tb/i4_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file tb/i4_stimulus.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok == "#") begin
                    code = $fgets(skip_line, fd);
                end else begin
                    test_name = tok;
                    run_record();
                end
            end
            $fclose(fd);
            if (test_count < 2) begin
                $display("ERROR: no test records were read from the stimulus file");
                err_count++;
            end
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb/i4_stimulus.txt */
# name lambda top_left top(17 px, px16 first) left(16 px, px15 first), 16 source rows
# then modes total, then 16 expected reconstruction rows; row 0 first, pixel 0 in low byte
flat128 0005 80 8080808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
00000000 0000000000000c80
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
tie0 0000 40 4040404040404040404040404040404040 40404040404040404040404040404040
40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040
40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040
00000000 0000000000000000
40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040
40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040
colstripe 0001 c0 40C040C040C040C040C040C040C040C040 80808080808080808080808080404040
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
00000002 0000000000000913
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
rowstripe 0001 80 8080808080808080808080808080808080 C040C040808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 81818181818181818282828270707070 81818181818181818282828280808080 81818181818181818282828280808080 818181818181818182828282A0A0A0A0
03000000 00000000000009aa
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080
80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 80808080808080808080808080808080 81818181818181818282828270707070 81818181818181818282828280808080 81818181818181818282828280808080 818181818181818182828282A0A0A0A0
flatdark 0100 10 1010101010101010101010101010101010 10101010101010101010101010101010
10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010
10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010
00000000 0000000000028000
10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010
10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010 10101010101010101010101010101010

/* src.f */
common/i4_pix_pkg.sv
common/i4_mode_pkg.sv
predict/i4_predictor.sv
predict/i4_edge_ctx.sv
score/i4_mode_scorer.sv
source/i4_mode_ctrl.sv
source/i4_mb_writeback.sv
source/i4_pick_best.sv
tb/tb_i4_pick_best.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i4_pick_best \
    -f src.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "PASS: all tests" sim.log
